//--- src/smc_pkg.sv
package smc_pkg;

	// ==============================
	// device array shape
	// ==============================

	localparam int unsigned NUM_DEV = 6;
	// sorted figures kept for scoring
	localparam int unsigned NUM_SEL = 3;

	// mode word bit positions
	localparam int unsigned MODE_CURRENT = 0;
	localparam int unsigned MODE_LARGEST = 1;

	// ==============================
	// data types
	// ==============================

	// width, gate and drain voltages, and overdrive
	typedef logic [2:0] volt_t;
	typedef logic [1:0] mode_t;
	// device figure, low 8 bits only
	typedef logic [7:0] drive_t;
	// figure divided by three, at most 85
	typedef logic [6:0] third_t;
	// weighted sum of three quotients, at most 1020
	typedef logic [9:0] wsum_t;
	typedef logic [6:0] score_t;

	// ==============================
	// score weights
	// ==============================

	// current mode, largest-ranked quotient first
	localparam wsum_t WEIGHT_LOW  = 10'd3;
	localparam wsum_t WEIGHT_MID  = 10'd4;
	localparam wsum_t WEIGHT_HIGH = 10'd5;
	// transconductance mode, same for all three
	localparam wsum_t WEIGHT_FLAT = 10'd4;

endpackage

//--- src/mosfet_model.sv
`timescale 1ns/100ps

module mosfet_model (
	input  smc_pkg::volt_t  w,
	input  smc_pkg::volt_t  v_gs,
	input  smc_pkg::volt_t  v_ds,
	input  logic            current_mode,
	output smc_pkg::drive_t figure
);

	import smc_pkg::*;

	volt_t       overdrive;
	logic        triode;
	volt_t       v_eff;
	logic [5:0]  w_v;
	logic [3:0]  factor;
	logic [9:0]  product;

	// threshold of one, wraps so v_gs of 0 gives 7
	assign overdrive = v_gs - 3'd1;

	// overdrive equal to v_ds counts as saturation
	assign triode = (overdrive > v_ds);
	assign v_eff  = triode ? v_ds : overdrive;

	assign w_v = {3'b000, w} * {3'b000, v_eff};

	// current: 2*ov - v_eff, never negative since v_eff <= ov
	// transconductance: constant 2
	always_comb begin
		if (current_mode) begin
			factor = {overdrive, 1'b0} - {1'b0, v_eff};
		end else begin
			factor = 4'd2;
		end
	end

	// up to 63 * 14, wider than the figure
	assign product = {4'b0000, w_v} * {6'b000000, factor};

	// only the low byte survives
	assign figure = product[7:0];

endmodule

//--- src/mosfet_array.sv
`timescale 1ns/100ps

module mosfet_array (
	input  logic            clk,
	input  logic            rst_n,
	input  smc_pkg::mode_t  mode,
	input  smc_pkg::volt_t  w      [smc_pkg::NUM_DEV],
	input  smc_pkg::volt_t  v_gs   [smc_pkg::NUM_DEV],
	input  smc_pkg::volt_t  v_ds   [smc_pkg::NUM_DEV],
	output smc_pkg::drive_t figure [smc_pkg::NUM_DEV],
	output smc_pkg::mode_t  mode_q
);

	import smc_pkg::*;

	drive_t figure_d [NUM_DEV];

	// ==============================
	// per-device evaluation
	// ==============================

	for (genvar i = 0; i < NUM_DEV; i++) begin : g_dev
		mosfet_model u_model (
			.w            (w[i]),
			.v_gs         (v_gs[i]),
			.v_ds         (v_ds[i]),
			.current_mode (mode[MODE_CURRENT]),
			.figure       (figure_d[i])
		);
	end

	// ==============================
	// stage 1 register
	// ==============================

	// mode travels with its figures so stage 2 scores the right vector
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_DEV; i++) begin
				figure[i] <= '0;
			end
			mode_q <= '0;
		end else begin
			for (int i = 0; i < NUM_DEV; i++) begin
				figure[i] <= figure_d[i];
			end
			mode_q <= mode;
		end
	end

endmodule

//--- src/sort_network.sv
`timescale 1ns/100ps

module sort_network (
	input  smc_pkg::drive_t figure [smc_pkg::NUM_DEV],
	output smc_pkg::drive_t sorted [smc_pkg::NUM_DEV]
);

	import smc_pkg::*;

	localparam int unsigned NUM_CMP = 12;

	// ==============================
	// comparator schedule
	// ==============================

	// each step leaves the larger value at cmp_hi
	// steps 0-5 sort even slots {0,2,4} and odd slots {1,3,5} as two triples
	// steps 6-8 pair the triples rank by rank
	// steps 9-11 merge the middle four
	localparam int unsigned CMP_HI [NUM_CMP] = '{
		1, 0, 3, 2, 1, 0,
		4, 2, 0,
		1, 3, 1
	};
	localparam int unsigned CMP_LO [NUM_CMP] = '{
		5, 4, 5, 4, 3, 2,
		5, 3, 1,
		4, 4, 2
	};

	drive_t work [NUM_DEV];
	drive_t held;

	// ==============================
	// compare-exchange chain
	// ==============================

	always_comb begin
		for (int i = 0; i < NUM_DEV; i++) begin
			work[i] = figure[i];
		end
		held = '0;
		for (int k = 0; k < NUM_CMP; k++) begin
			// equal values stay where they are
			if (work[CMP_HI[k]] < work[CMP_LO[k]]) begin
				held             = work[CMP_HI[k]];
				work[CMP_HI[k]]  = work[CMP_LO[k]];
				work[CMP_LO[k]]  = held;
			end
		end
	end

	// index 0 is the largest figure
	always_comb begin
		for (int i = 0; i < NUM_DEV; i++) begin
			sorted[i] = work[i];
		end
	end

endmodule

//--- src/score_average.sv
`timescale 1ns/100ps

module score_average (
	input  logic            clk,
	input  logic            rst_n,
	input  smc_pkg::drive_t sorted [smc_pkg::NUM_DEV],
	input  smc_pkg::mode_t  mode_q,
	output smc_pkg::score_t score
);

	import smc_pkg::*;

	drive_t kept [NUM_SEL];
	third_t quot [NUM_SEL];
	wsum_t  w_first;
	wsum_t  w_mid;
	wsum_t  w_last;
	wsum_t  wsum;
	score_t score_d;

	// ==============================
	// top or bottom three
	// ==============================

	// kept[0] is always the highest-ranked of the chosen three
	always_comb begin
		for (int i = 0; i < NUM_SEL; i++) begin
			if (mode_q[MODE_LARGEST]) begin
				kept[i] = sorted[i];
			end else begin
				kept[i] = sorted[i + NUM_SEL];
			end
			// at most 255 / 3 = 85, fits in 7 bits
			quot[i] = third_t'(kept[i] / drive_t'(3));
		end
	end

	// ==============================
	// weighting and final divide
	// ==============================

	assign w_first = mode_q[MODE_CURRENT] ? WEIGHT_LOW  : WEIGHT_FLAT;
	assign w_mid   = mode_q[MODE_CURRENT] ? WEIGHT_MID  : WEIGHT_FLAT;
	assign w_last  = mode_q[MODE_CURRENT] ? WEIGHT_HIGH : WEIGHT_FLAT;

	// weights add to 12 either way, so the sum stays under 1024
	assign wsum = w_first * wsum_t'(quot[0])
		+ w_mid  * wsum_t'(quot[1])
		+ w_last * wsum_t'(quot[2]);

	assign score_d = score_t'(wsum / wsum_t'(12));

	// stage 2 register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score <= '0;
		end else begin
			score <= score_d;
		end
	end

endmodule

//--- src/smc.sv
`timescale 1ns/100ps

module smc (
	input  logic           clk,
	input  logic           rst_n,
	input  smc_pkg::mode_t mode,
	input  smc_pkg::volt_t w_0,
	input  smc_pkg::volt_t v_gs_0,
	input  smc_pkg::volt_t v_ds_0,
	input  smc_pkg::volt_t w_1,
	input  smc_pkg::volt_t v_gs_1,
	input  smc_pkg::volt_t v_ds_1,
	input  smc_pkg::volt_t w_2,
	input  smc_pkg::volt_t v_gs_2,
	input  smc_pkg::volt_t v_ds_2,
	input  smc_pkg::volt_t w_3,
	input  smc_pkg::volt_t v_gs_3,
	input  smc_pkg::volt_t v_ds_3,
	input  smc_pkg::volt_t w_4,
	input  smc_pkg::volt_t v_gs_4,
	input  smc_pkg::volt_t v_ds_4,
	input  smc_pkg::volt_t w_5,
	input  smc_pkg::volt_t v_gs_5,
	input  smc_pkg::volt_t v_ds_5,
	output logic [7:0]     out_n
);

	import smc_pkg::*;

	volt_t  w_arr    [NUM_DEV];
	volt_t  v_gs_arr [NUM_DEV];
	volt_t  v_ds_arr [NUM_DEV];
	drive_t figure   [NUM_DEV];
	drive_t sorted   [NUM_DEV];
	mode_t  mode_q;
	score_t score;

	// ==============================
	// gather device inputs
	// ==============================

	assign w_arr    = '{w_0, w_1, w_2, w_3, w_4, w_5};
	assign v_gs_arr = '{v_gs_0, v_gs_1, v_gs_2, v_gs_3, v_gs_4, v_gs_5};
	assign v_ds_arr = '{v_ds_0, v_ds_1, v_ds_2, v_ds_3, v_ds_4, v_ds_5};

	// ==============================
	// pipeline
	// ==============================

	// stage 1, figures and mode registered
	mosfet_array u_array (
		.clk    (clk),
		.rst_n  (rst_n),
		.mode   (mode),
		.w      (w_arr),
		.v_gs   (v_gs_arr),
		.v_ds   (v_ds_arr),
		.figure (figure),
		.mode_q (mode_q)
	);

	sort_network u_sort (
		.figure (figure),
		.sorted (sorted)
	);

	// stage 2, score registered
	score_average u_score (
		.clk    (clk),
		.rst_n  (rst_n),
		.sorted (sorted),
		.mode_q (mode_q),
		.score  (score)
	);

	// top bit is always zero
	assign out_n = {1'b0, score};

endmodule

//--- tests/smc_props.sv
`timescale 1ns/100ps

module smc_props (
	input logic       clk,
	input logic       rst_n,
	input logic [7:0] out_n
);

	// ==============================
	// output range
	// ==============================

	// each quotient is at most 85 and the weights add up to 12
	a_score_max: assert property (
		@(posedge clk) disable iff (!rst_n) out_n <= 8'd85
	) else $error("out_n is above 85");

	// ==============================
	// reset behavior
	// ==============================

	// checked on the falling edge once the async clear has settled
	a_reset_zero: assert property (
		@(negedge clk) !rst_n |-> out_n == 8'h00
	) else $error("out_n is not zero during reset");

	// stage 1 still holds its reset zeros at the first edge after release
	a_zero_after_release: assert property (
		@(posedge clk) $rose(rst_n) |=> out_n == 8'h00
	) else $error("out_n is not zero at the first edge after reset release");

	a_no_unknown: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(out_n)
	) else $error("out_n is unknown after reset");

endmodule

bind smc smc_props u_props (
	.clk   (clk),
	.rst_n (rst_n),
	.out_n (out_n)
);

//--- tests/smc_tb.sv
`timescale 1ns/100ps

module smc_tb;

	import smc_pkg::*;

	localparam int    CLK_HALF      = 20;
	localparam int    RESET_CYCLES  = 16;
	localparam int    CLEAR_TIMEOUT = 4;
	localparam int    DRAIN_TIMEOUT = 8;
	localparam int    NUM_FIELDS    = 20;
	localparam string GOLDEN_FILE   = "tests/smc_golden.txt";

	logic       clk;
	logic       rst_n;
	mode_t      mode;
	volt_t      w_0, v_gs_0, v_ds_0;
	volt_t      w_1, v_gs_1, v_ds_1;
	volt_t      w_2, v_gs_2, v_ds_2;
	volt_t      w_3, v_gs_3, v_ds_3;
	volt_t      w_4, v_gs_4, v_ds_4;
	volt_t      w_5, v_gs_5, v_ds_5;
	logic [7:0] out_n;

	// golden vectors, device triples packed 9 bits apart
	mode_t       vec_mode [$];
	logic [53:0] vec_dev  [$];
	logic [7:0]  vec_exp  [$];
	// expectations still inside the two-stage pipeline
	logic [7:0]  exp_q    [$];
	int          errors;

	always #CLK_HALF clk = ~clk;

	smc UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.mode   (mode),
		.w_0    (w_0),
		.v_gs_0 (v_gs_0),
		.v_ds_0 (v_ds_0),
		.w_1    (w_1),
		.v_gs_1 (v_gs_1),
		.v_ds_1 (v_ds_1),
		.w_2    (w_2),
		.v_gs_2 (v_gs_2),
		.v_ds_2 (v_ds_2),
		.w_3    (w_3),
		.v_gs_3 (v_gs_3),
		.v_ds_3 (v_ds_3),
		.w_4    (w_4),
		.v_gs_4 (v_gs_4),
		.v_ds_4 (v_ds_4),
		.w_5    (w_5),
		.v_gs_5 (v_gs_5),
		.v_ds_5 (v_ds_5),
		.out_n  (out_n)
	);

	// ==============================
	// reporting
	// ==============================

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic fail_plain(string reason);
		$display("ERROR: %s", reason);
		abort_run();
	endtask

	task automatic check_value(string name, logic [7:0] actual, logic [7:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
			abort_run();
		end
	endtask

	// ==============================
	// golden file
	// ==============================

	function automatic bit is_blank(string s);
		bit blank;
		blank = 1'b1;
		for (int i = 0; i < s.len(); i++) begin
			if (s[i] != " " && s[i] != "\t" && s[i] != "\n" && s[i] != "\r") begin
				blank = 1'b0;
			end
		end
		return blank;
	endfunction

	task automatic load_golden();
		int          fd;
		int          n;
		int          line_no;
		bit          bad;
		string       line;
		int unsigned fld [NUM_FIELDS];
		logic [53:0] dev;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			fail_plain("cannot open the golden vector file tests/smc_golden.txt");
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				line_no++;
				if (n > 0 && !is_blank(line) && line[0] != "#") begin
					n = $sscanf(line,
						"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
						fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
						fld[14], fld[15], fld[16], fld[17], fld[18], fld[19]);
					// mode is 2 bits, device values 3 bits, expected score 8 bits
					bad = (n != NUM_FIELDS) || (fld[0] > 3) || (fld[19] > 8'hff);
					for (int k = 1; k <= 18; k++) begin
						if (fld[k] > 7) begin
							bad = 1'b1;
						end
					end
					if (bad) begin
						fail_plain($sformatf("line %0d of the golden file is malformed", line_no));
					end else begin
						for (int k = 0; k < 18; k++) begin
							dev[3*k +: 3] = fld[k+1][2:0];
						end
						vec_mode.push_back(mode_t'(fld[0]));
						vec_dev.push_back(dev);
						vec_exp.push_back(fld[19][7:0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ==============================
	// stimulus and checking
	// ==============================

	task automatic drive_vector(mode_t m, logic [53:0] d);
		mode   <= m;
		w_0    <= d[2:0];
		v_gs_0 <= d[5:3];
		v_ds_0 <= d[8:6];
		w_1    <= d[11:9];
		v_gs_1 <= d[14:12];
		v_ds_1 <= d[17:15];
		w_2    <= d[20:18];
		v_gs_2 <= d[23:21];
		v_ds_2 <= d[26:24];
		w_3    <= d[29:27];
		v_gs_3 <= d[32:30];
		v_ds_3 <= d[35:33];
		w_4    <= d[38:36];
		v_gs_4 <= d[41:39];
		v_ds_4 <= d[44:42];
		w_5    <= d[47:45];
		v_gs_5 <= d[50:48];
		v_ds_5 <= d[53:51];
	endtask

	// out_n after edge n belongs to the vector driven at edge n-2
	task automatic compare_step();
		logic [7:0] expected;
		if (exp_q.size() == 2) begin
			expected = exp_q.pop_front();
			check_value("out_n", out_n, expected);
		end else begin
			// pipeline still holds the idle inputs from reset
			check_value("out_n", out_n, 8'h00);
		end
	endtask

	initial begin
		int         cycles;
		logic [7:0] expected;
		errors = 0;
		clk    = 1'b0;
		rst_n <= 1'b0;
		drive_vector('0, '0);

		load_golden();
		if (vec_exp.size() == 0) begin
			fail_plain("the golden file holds no vectors");
		end
		$display("loaded %0d golden vectors", vec_exp.size());

		// wait for the async clear, then hold reset
		cycles = 0;
		while (out_n !== 8'h00) begin
			if (cycles == CLEAR_TIMEOUT) begin
				fail_plain("out_n did not clear while reset was asserted");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		while (cycles < RESET_CYCLES) begin
			@(negedge clk);
			check_value("out_n", out_n, 8'h00);
			cycles++;
		end
		rst_n <= 1'b1;

		// one vector per cycle, modes change freely between vectors
		for (int i = 0; i < vec_exp.size(); i++) begin
			@(posedge clk);
			drive_vector(vec_mode[i], vec_dev[i]);
			@(negedge clk);
			compare_step();
			exp_q.push_back(vec_exp[i]);
		end

		// last two vectors still in flight
		cycles = 0;
		while (exp_q.size() > 0) begin
			if (cycles == DRAIN_TIMEOUT) begin
				fail_plain("pipeline did not drain after the last vector");
			end else begin
				@(posedge clk);
				@(negedge clk);
				expected = exp_q.pop_front();
				check_value("out_n", out_n, expected);
				cycles++;
			end
		end

		if (errors == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- list.f
src/smc_pkg.sv
src/mosfet_model.sv
src/mosfet_array.sv
src/sort_network.sv
src/score_average.sv
src/smc.sv
tests/smc_props.sv
tests/smc_tb.sv

//--- tests/smc_golden.txt
# mode, then w v_gs v_ds for devices 0 to 5, then expected out_n
# all fields in hex, one vector per line
3 1 2 1 2 3 1 3 4 3 5 6 2 7 7 3 6 7 6 31
3 3 4 3 4 3 5 5 5 4 4 6 3 7 6 7 3 5 1 22
3 3 4 3 5 5 4 6 7 6 7 6 7 1 4 7 2 7 5 30
3 5 6 2 7 0 6 4 6 3 7 0 3 5 0 7 6 0 5 39
1 0 5 2 6 7 6 7 7 3 5 6 2 5 5 4 7 6 7 0f
1 2 1 4 7 0 7 4 6 3 4 3 5 1 4 7 5 0 7 02
1 7 0 0 6 7 6 7 7 3 7 0 3 5 0 7 7 6 7 23
1 5 6 2 5 5 4 4 6 3 7 0 6 2 7 5 4 0 7 18
2 6 7 6 7 7 3 7 0 6 5 0 7 6 0 7 7 0 7 1d
2 1 2 1 2 3 1 3 4 3 5 6 2 7 7 3 6 7 6 0e
0 1 2 1 2 3 1 3 4 3 5 6 2 7 7 3 6 7 6 02
0 7 0 7 7 0 6 6 0 7 4 0 7 7 6 7 5 0 7 15
0 3 4 3 5 5 4 4 6 3 2 7 5 6 0 5 7 0 3 06
2 3 4 3 5 5 4 4 6 3 2 7 5 6 0 5 7 0 3 0f
3 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 54
2 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 1c
1 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 54
0 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 1c
3 7 0 7 7 0 6 7 0 3 6 0 5 5 0 7 6 0 7 3a
1 7 0 7 7 0 6 7 0 3 6 0 5 5 0 7 6 0 7 0c
3 7 0 5 6 0 6 7 0 4 5 0 6 6 0 4 3 0 7 43
1 7 0 5 6 0 6 7 0 4 5 0 6 6 0 4 3 0 7 0b
3 5 6 2 7 0 6 5 5 4 5 5 7 5 6 2 7 0 6 1a
3 4 6 3 4 6 3 5 6 2 7 0 6 5 5 4 4 0 7 25
1 4 6 3 4 6 3 5 6 2 7 0 6 5 5 4 4 0 7 1a
2 7 0 6 6 0 7 7 7 7 6 7 6 6 0 6 0 5 2 1c
0 7 0 6 6 0 7 7 7 7 6 7 6 6 0 6 0 5 2 10
3 3 4 3 4 3 5 5 5 4 4 6 3 7 6 7 3 5 1 22
0 3 4 3 4 3 5 5 5 4 4 6 3 7 6 7 3 5 1 04
1 3 4 3 4 3 5 5 5 4 4 6 3 7 6 7 3 5 1 06
2 3 4 3 4 3 5 5 5 4 4 6 3 7 6 7 3 5 1 0e
3 5 6 2 7 0 6 4 6 3 7 0 3 5 0 7 6 0 5 39
2 5 6 2 7 0 6 4 6 3 7 0 3 5 0 7 6 0 5 17
1 5 6 2 7 0 6 4 6 3 7 0 3 5 0 7 6 0 5 10
0 5 6 2 7 0 6 4 6 3 7 0 3 5 0 7 6 0 5 09
3 7 0 7 7 0 6 7 0 3 6 0 5 5 0 7 6 0 7 3a
0 7 0 7 7 0 6 7 0 3 6 0 5 5 0 7 6 0 7 13
2 7 0 7 7 0 6 7 0 3 6 0 5 5 0 7 6 0 7 1d
1 7 0 7 7 0 6 7 0 3 6 0 5 5 0 7 6 0 7 0c
3 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 54
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
3 1 2 1 2 3 1 3 4 3 5 6 2 7 7 3 6 7 6 31
